//--- usb_fs_receiver.f
src/usb_rx_pkg.sv
src/usb_rx_line_recovery.sv
src/usb_rx_framer.sv
src/usb_rx_bit_decoder.sv
src/usb_rx_crc_check.sv
src/usb_rx_packet_decoder.sv
src/usb_fs_receiver.sv
sim/tb_usb_fs_receiver.sv

//--- Bender.yml
package:
  name: usb_fs_receiver

sources:
  - src/usb_rx_pkg.sv
  - src/usb_rx_line_recovery.sv
  - src/usb_rx_framer.sv
  - src/usb_rx_bit_decoder.sv
  - src/usb_rx_crc_check.sv
  - src/usb_rx_packet_decoder.sv
  - src/usb_fs_receiver.sv
  - target: simulation
    files:
      - sim/tb_usb_fs_receiver.sv

//--- sim/tb_usb_fs_receiver.sv
/*
 * testbench for the USB full-speed receiver
 * encodes packets onto D+/D- and checks the decoded fields, bytes and flags
 */
`timescale 1ns/1ps

module tb_usb_fs_receiver
  import usb_rx_pkg::*;
();

  // both CRCs are computed lsb first, so the polynomial taps appear mirrored
  localparam logic [4:0]  CRC5_MIRRORED  = 5'b10100;
  localparam logic [15:0] CRC16_MIRRORED = 16'hA001;
  localparam int unsigned WAIT_LIMIT     = 400;

  logic        clk_i, rst_ni, usb_dp_i, usb_dn_i;
  logic        bit_strobe, pkt_start, pkt_end, rx_data_put;
  logic        valid_pid, valid_packet, crc5_error, crc16_error, pid_error, bitstuff_error;
  usb_pid_e    pid;
  logic [6:0]  addr;
  logic [3:0]  endp;
  logic [10:0] frame_num;
  logic [7:0]  rx_data;

  // what the monitor saw in the end of packet cycle
  bit          start_seen, end_seen, end_after_start;
  int          end_count;
  usb_pid_e    end_pid;
  logic [6:0]  end_addr;
  logic [3:0]  end_endp;
  logic [10:0] end_frame;
  logic        end_valid_pid, end_valid_packet, end_crc5_err, end_crc16_err;
  logic        end_pid_err, end_stuff_err;

  // clocks since the last bit strobe, and whether a packet is on the line
  int          strobe_gap;
  bit          in_frame;

  logic [7:0]  rx_bytes_q[$];
  logic [7:0]  tx_bytes_q[$];
  bit          payload_q[$];
  bit          stream_q[$];
  logic [6:0]  tok_addr;
  logic [3:0]  tok_endp;
  int          seed;

  always #5 clk_i = ~clk_i;

  usb_fs_receiver i_dut (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .usb_dp_i         (usb_dp_i),
    .usb_dn_i         (usb_dn_i),
    .bit_strobe_o     (bit_strobe),
    .pkt_start_o      (pkt_start),
    .pkt_end_o        (pkt_end),
    .pid_o            (pid),
    .addr_o           (addr),
    .endp_o           (endp),
    .frame_num_o      (frame_num),
    .rx_data_put_o    (rx_data_put),
    .rx_data_o        (rx_data),
    .valid_pid_o      (valid_pid),
    .valid_packet_o   (valid_packet),
    .crc5_error_o     (crc5_error),
    .crc16_error_o    (crc16_error),
    .pid_error_o      (pid_error),
    .bitstuff_error_o (bitstuff_error)
  );

  // outputs are taken on the falling edge where they have settled
  always @(negedge clk_i) begin
    // inside a packet every symbol lasts four clocks, so the strobes do too
    strobe_gap = strobe_gap + 1;
    if (bit_strobe) begin
      if (in_frame && strobe_gap != 4) begin
        fail_run($sformatf("bit_strobe_o came %0d clocks after the previous one, not 4",
                           strobe_gap));
      end
      strobe_gap = 0;
    end
    if (pkt_start) begin
      // the framer registers the sample, so start lines up with the strobe phase
      if (!bit_strobe) begin
        fail_run("bit_strobe_o was low in the cycle of the start of packet pulse");
      end
      in_frame   = 1'b1;
      start_seen = 1'b1;
    end
    if (rx_data_put) begin
      rx_bytes_q.push_back(rx_data);
    end
    if (pkt_end) begin
      in_frame         = 1'b0;
      end_after_start  = start_seen;
      end_pid          = pid;
      end_addr         = addr;
      end_endp         = endp;
      end_frame        = frame_num;
      end_valid_pid    = valid_pid;
      end_valid_packet = valid_packet;
      end_crc5_err     = crc5_error;
      end_crc16_err    = crc16_error;
      end_pid_err      = pid_error;
      end_stuff_err    = bitstuff_error;
      end_count        = end_count + 1;
      end_seen         = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // reporting and compare tasks
  //////////////////////////////////////////////////

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic check_pid(input string name, input usb_pid_e got, input usb_pid_e exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_field(input string name, input logic [10:0] got, input logic [10:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // reference CRCs and packet building
  //////////////////////////////////////////////////

  function automatic crc5_t crc5_step(input crc5_t crc, input logic b);
    if (crc[0] ^ b) begin
      return (crc >> 1) ^ CRC5_MIRRORED;
    end
    return crc >> 1;
  endfunction

  function automatic crc16_t crc16_step(input crc16_t crc, input logic b);
    if (crc[0] ^ b) begin
      return (crc >> 1) ^ CRC16_MIRRORED;
    end
    return crc >> 1;
  endfunction

  // the upper nibble of the PID byte is the complement of the lower one
  function automatic logic [7:0] pid_byte(input usb_pid_e p);
    return {~p, p};
  endfunction

  // 11 token bits, address first, then the inverted CRC5 lsb first
  task automatic build_token(input logic [6:0] a, input logic [3:0] e, input bit bad_crc);
    logic [10:0] field;
    crc5_t       crc;
    field = {e, a};
    crc   = '1;
    payload_q.delete();
    for (int i = 0; i < 11; i++) begin
      payload_q.push_back(field[i]);
      crc = crc5_step(crc, field[i]);
    end
    crc = ~crc;
    if (bad_crc) begin
      crc[2] = ~crc[2];
    end
    for (int i = 0; i < 5; i++) begin
      payload_q.push_back(crc[i]);
    end
  endtask

  // the sent CRC bytes are appended so tx_bytes_q holds every expected byte
  task automatic build_data(input bit with_crc, input bit bad_crc);
    crc16_t     crc;
    logic [7:0] b;
    crc = '1;
    payload_q.delete();
    for (int i = 0; i < tx_bytes_q.size(); i++) begin
      b = tx_bytes_q[i];
      for (int j = 0; j < 8; j++) begin
        crc = crc16_step(crc, b[j]);
      end
    end
    crc = ~crc;
    if (bad_crc) begin
      crc[9] = ~crc[9];
    end
    if (with_crc) begin
      tx_bytes_q.push_back(crc[7:0]);
      tx_bytes_q.push_back(crc[15:8]);
    end
    for (int i = 0; i < tx_bytes_q.size(); i++) begin
      b = tx_bytes_q[i];
      for (int j = 0; j < 8; j++) begin
        payload_q.push_back(b[j]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // line encoder
  //////////////////////////////////////////////////

  // one symbol lasts four clocks, the bit rate of the DUT's sampling
  task automatic drive_pair(input logic dp, input logic dn);
    @(posedge clk_i);
    usb_dp_i <= dp;
    usb_dn_i <= dn;
    repeat (3) @(posedge clk_i);
  endtask

  // level 1 is J and level 0 is K
  task automatic drive_level(input logic level);
    drive_pair(level, ~level);
  endtask

  task automatic send_packet(input logic [7:0] pid_bits, input bit stuff_en);
    logic level;
    int   ones;
    stream_q.delete();
    for (int i = 0; i < 8; i++) begin
      stream_q.push_back(pid_bits[i]);
    end
    foreach (payload_q[i]) begin
      stream_q.push_back(payload_q[i]);
    end
    level = 1'b1;
    repeat (4) drive_level(level);
    // sync is seven zeros and a one, each zero toggles the line
    for (int i = 0; i < 8; i++) begin
      if (i < 7) begin
        level = ~level;
      end
      drive_level(level);
    end
    // the run of ones counts from the first PID bit
    ones = 0;
    foreach (stream_q[i]) begin
      if (stream_q[i]) begin
        ones = ones + 1;
      end else begin
        level = ~level;
        ones  = 0;
      end
      drive_level(level);
      if (stuff_en && ones == 6) begin
        level = ~level;
        ones  = 0;
        drive_level(level);
      end
    end
    drive_pair(1'b0, 1'b0);
    drive_pair(1'b0, 1'b0);
    drive_pair(1'b1, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // waits and end of packet checks
  //////////////////////////////////////////////////

  task automatic clear_capture();
    start_seen = 1'b0;
    end_seen   = 1'b0;
    end_count  = 0;
    rx_bytes_q.delete();
  endtask

  task automatic wait_packet_end();
    int cycles;
    cycles = 0;
    while (!end_seen) begin
      @(negedge clk_i);
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        fail_run("timeout: the end of packet pulse never arrived");
      end
    end
  endtask

  task automatic wait_bytes(input int n);
    int cycles;
    cycles = 0;
    while (rx_bytes_q.size() < n) begin
      @(negedge clk_i);
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        fail_run("timeout: fewer data bytes arrived than were sent");
      end
    end
    if (rx_bytes_q.size() != n) begin
      fail_run("more data bytes arrived than were sent");
    end
  endtask

  task automatic expect_end(input logic vpid, input logic vpkt, input logic c5,
                            input logic c16, input logic perr, input logic serr);
    if (!end_after_start) begin
      fail_run("end of packet arrived without a start of packet pulse before it");
    end
    if (end_count != 1) begin
      fail_run("end of packet pulsed more than once for one packet");
    end
    check_flag("valid_pid_o", end_valid_pid, vpid);
    check_flag("valid_packet_o", end_valid_packet, vpkt);
    check_flag("crc5_error_o", end_crc5_err, c5);
    check_flag("crc16_error_o", end_crc16_err, c16);
    check_flag("pid_error_o", end_pid_err, perr);
    check_flag("bitstuff_error_o", end_stuff_err, serr);
  endtask

  task automatic compare_bytes();
    for (int i = 0; i < tx_bytes_q.size(); i++) begin
      check_byte("rx_data_o", rx_bytes_q[i], tx_bytes_q[i]);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic good_token_test();
    tok_addr = 7'($random(seed));
    tok_endp = 4'($random(seed));
    build_token(tok_addr, tok_endp, 1'b0);
    clear_capture();
    send_packet(pid_byte(PID_OUT), 1'b1);
    wait_packet_end();
    check_pid("pid_o", end_pid, PID_OUT);
    check_field("addr_o", 11'(end_addr), 11'(tok_addr));
    check_field("endp_o", 11'(end_endp), 11'(tok_endp));
    // a frame number spans the same 11 bits as address and endpoint
    check_field("frame_num_o", end_frame, {tok_endp, tok_addr});
    expect_end(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic bad_crc5_test();
    build_token(tok_addr, tok_endp, 1'b1);
    clear_capture();
    send_packet(pid_byte(PID_OUT), 1'b1);
    wait_packet_end();
    expect_end(1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic data_packet_test();
    tx_bytes_q.delete();
    repeat (6) tx_bytes_q.push_back(8'($random(seed)));
    build_data(1'b1, 1'b0);
    clear_capture();
    send_packet(pid_byte(PID_DATA0), 1'b1);
    wait_packet_end();
    wait_bytes(8);
    compare_bytes();
    check_pid("pid_o", end_pid, PID_DATA0);
    expect_end(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic bit_stuffing_test();
    tx_bytes_q = '{8'hFF, 8'h3F, 8'hFF, 8'h7E};
    build_data(1'b1, 1'b0);
    clear_capture();
    send_packet(pid_byte(PID_DATA1), 1'b1);
    wait_packet_end();
    wait_bytes(6);
    compare_bytes();
    expect_end(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // the same ones without stuffed zeros must cut the packet short
    tx_bytes_q = '{8'hFF, 8'hFF};
    build_data(1'b0, 1'b0);
    clear_capture();
    send_packet(pid_byte(PID_DATA1), 1'b0);
    wait_packet_end();
    check_flag("bitstuff_error_o", end_stuff_err, 1'b1);
    check_flag("valid_packet_o", end_valid_packet, 1'b0);
    check_flag("pid_error_o", end_pid_err, 1'b0);
  endtask

  task automatic bad_crc16_test();
    tx_bytes_q.delete();
    repeat (4) tx_bytes_q.push_back(8'($random(seed)));
    build_data(1'b1, 1'b1);
    clear_capture();
    send_packet(pid_byte(PID_DATA0), 1'b1);
    wait_packet_end();
    expect_end(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
  endtask

  task automatic handshake_test();
    payload_q.delete();
    clear_capture();
    send_packet(pid_byte(PID_ACK), 1'b1);
    wait_packet_end();
    check_pid("pid_o", end_pid, PID_ACK);
    expect_end(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    // ACK in both nibbles, so the check nibble is wrong
    clear_capture();
    send_packet(8'h22, 1'b1);
    wait_packet_end();
    expect_end(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
  endtask

  initial begin
    seed     = 4;
    clk_i    = 1'b0;
    rst_ni   = 1'b0;
    usb_dp_i = 1'b1;
    usb_dn_i = 1'b0;
    repeat (10) @(posedge clk_i);
    rst_ni <= 1'b1;
    good_token_test();
    bad_crc5_test();
    data_packet_test();
    bit_stuffing_test();
    bad_crc16_test();
    handshake_test();
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- src/usb_fs_receiver.sv
/*
 * USB full-speed packet receiver
 * line recovery, framing, bit decode, CRC checks and packet decode
 */
`timescale 1ns/1ps

module usb_fs_receiver
  import usb_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        usb_dp_i,
  input  logic        usb_dn_i,
  output logic        bit_strobe_o,
  output logic        pkt_start_o,
  output logic        pkt_end_o,
  output usb_pid_e    pid_o,
  output logic [6:0]  addr_o,
  output logic [3:0]  endp_o,
  output logic [10:0] frame_num_o,
  output logic        rx_data_put_o,
  output logic [7:0]  rx_data_o,
  output logic        valid_pid_o,
  output logic        valid_packet_o,
  output logic        crc5_error_o,
  output logic        crc16_error_o,
  output logic        pid_error_o,
  output logic        bitstuff_error_o
);

  line_state_e line_state;
  logic        sample_valid;
  logic [3:0]  sym_history;
  logic        packet_valid, packet_start;
  logic        din, dvalid, bitstuff_err;
  logic        payload_valid, crc5_ok, crc16_ok;

  usb_rx_line_recovery i_line_recovery (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .usb_dp_i       (usb_dp_i),
    .usb_dn_i       (usb_dn_i),
    .line_state_o   (line_state),
    .sample_valid_o (sample_valid),
    .bit_strobe_o   (bit_strobe_o)
  );

  // pkt_end_o is the framer's end pulse and also feeds the later stages
  usb_rx_framer i_framer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .line_state_i   (line_state),
    .sample_valid_i (sample_valid),
    .bitstuff_err_i (bitstuff_err),
    .sym_history_o  (sym_history),
    .packet_valid_o (packet_valid),
    .packet_start_o (packet_start),
    .packet_end_o   (pkt_end_o),
    .sop_o          (pkt_start_o)
  );

  usb_rx_bit_decoder i_bit_decoder (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .sym_history_i  (sym_history),
    .sample_valid_i (sample_valid),
    .packet_valid_i (packet_valid),
    .packet_start_i (packet_start),
    .packet_end_i   (pkt_end_o),
    .din_o          (din),
    .dvalid_o       (dvalid),
    .bitstuff_err_o (bitstuff_err)
  );

  // both checkers see every payload bit, the decoder picks by packet class
  usb_rx_crc_check #(
    .crc_t   (crc5_t),
    .POLY    (CRC5_POLY),
    .RESIDUE (CRC5_RESIDUE)
  ) i_crc5 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (packet_start),
    .bit_i       (din),
    .bit_valid_i (payload_valid),
    .crc_ok_o    (crc5_ok)
  );

  usb_rx_crc_check #(
    .crc_t   (crc16_t),
    .POLY    (CRC16_POLY),
    .RESIDUE (CRC16_RESIDUE)
  ) i_crc16 (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (packet_start),
    .bit_i       (din),
    .bit_valid_i (payload_valid),
    .crc_ok_o    (crc16_ok)
  );

  usb_rx_packet_decoder i_packet_decoder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .din_i            (din),
    .dvalid_i         (dvalid),
    .packet_start_i   (packet_start),
    .packet_end_i     (pkt_end_o),
    .bitstuff_err_i   (bitstuff_err),
    .crc5_ok_i        (crc5_ok),
    .crc16_ok_i       (crc16_ok),
    .payload_valid_o  (payload_valid),
    .pid_o            (pid_o),
    .addr_o           (addr_o),
    .endp_o           (endp_o),
    .frame_num_o      (frame_num_o),
    .rx_data_put_o    (rx_data_put_o),
    .rx_data_o        (rx_data_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .crc5_error_o     (crc5_error_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

endmodule

//--- src/usb_rx_packet_decoder.sv
/*
 * USB receive packet decoder
 * checks PID and length, extracts token fields and data bytes, forms error pulses
 */
`timescale 1ns/1ps

module usb_rx_packet_decoder
  import usb_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        din_i,
  input  logic        dvalid_i,
  input  logic        packet_start_i,
  input  logic        packet_end_i,
  input  logic        bitstuff_err_i,
  input  logic        crc5_ok_i,
  input  logic        crc16_ok_i,
  output logic        payload_valid_o,
  output usb_pid_e    pid_o,
  output logic [6:0]  addr_o,
  output logic [3:0]  endp_o,
  output logic [10:0] frame_num_o,
  output logic        rx_data_put_o,
  output logic [7:0]  rx_data_o,
  output logic        valid_pid_o,
  output logic        valid_packet_o,
  output logic        crc5_error_o,
  output logic        crc16_error_o,
  output logic        pid_error_o,
  output logic        bitstuff_error_o
);

  logic [8:0]  full_pid_q;
  logic [11:0] token_q;
  logic [8:0]  rx_buf_q;
  logic [3:0]  len_q;
  logic        len16_q;
  logic        pid_complete, pid_ok, token_done;
  logic        is_token, is_data, is_handshake;
  logic        token_len_ok, data_len_ok, handshake_len_ok;
  pid_kind_e   kind;

  //////////////////////////////////////////////////
  // PID capture
  //////////////////////////////////////////////////

  // the sentinel one falls out at bit 0 once all eight PID bits are in
  assign pid_complete    = full_pid_q[0];
  assign pid_ok          = (full_pid_q[4:1] == ~full_pid_q[8:5]);
  assign payload_valid_o = dvalid_i & pid_complete;
  assign pid_o           = usb_pid_e'(full_pid_q[4:1]);
  assign kind            = pid_kind_e'(full_pid_q[2:1]);
  assign is_token        = (kind == KIND_TOKEN);
  assign is_data         = (kind == KIND_DATA);
  assign is_handshake    = (kind == KIND_HANDSHAKE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_pid_q <= '0;
    end else if (packet_start_i) begin
      full_pid_q <= 9'h100;
    end else if (dvalid_i && !pid_complete) begin
      full_pid_q <= {din_i, full_pid_q[8:1]};
    end
  end

  //////////////////////////////////////////////////
  // payload length
  //////////////////////////////////////////////////

  // len16 sticks once 16 bits have passed, len counts modulo 16
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      len16_q <= 1'b0;
      len_q   <= 4'd0;
    end else if (packet_start_i) begin
      len16_q <= 1'b0;
      len_q   <= 4'd0;
    end else if (payload_valid_o) begin
      len16_q <= len16_q | (&len_q);
      len_q   <= len_q + 4'd1;
    end
  end

  assign token_len_ok     = len16_q & ~|len_q;
  // data must be byte aligned and hold at least the CRC16
  assign data_len_ok      = len16_q & ~|len_q[2:0];
  assign handshake_len_ok = ~|{len16_q, len_q};

  //////////////////////////////////////////////////
  // token fields and data bytes
  //////////////////////////////////////////////////

  assign token_done = token_q[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      token_q     <= '0;
      addr_o      <= '0;
      endp_o      <= '0;
      frame_num_o <= '0;
    end else begin
      if (packet_start_i) begin
        token_q <= 12'h800;
      end else if (payload_valid_o && is_token && !token_done) begin
        token_q <= {din_i, token_q[11:1]};
      end
      // frame number of a SOF overlaps address and endpoint of other tokens
      if (token_done && is_token) begin
        addr_o      <= token_q[7:1];
        endp_o      <= token_q[11:8];
        frame_num_o <= token_q[11:1];
      end
    end
  end

  // byte buffer with sentinel, the full flag is the one-cycle put strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_buf_q <= '0;
    end else if (payload_valid_o && is_data) begin
      rx_buf_q <= {din_i, rx_buf_q[8:1]};
    end else if (packet_start_i || rx_buf_q[0]) begin
      rx_buf_q <= 9'h100;
    end
  end

  assign rx_data_put_o = rx_buf_q[0];
  assign rx_data_o     = rx_buf_q[8:1];

  //////////////////////////////////////////////////
  // status and errors
  //////////////////////////////////////////////////

  assign valid_pid_o    = pid_ok;
  assign valid_packet_o = pid_ok & ~bitstuff_err_i &
                          ((is_handshake & handshake_len_ok) |
                           (is_data & data_len_ok & crc16_ok_i) |
                           (is_token & token_len_ok & crc5_ok_i));

  // error pulses only exist in the end of packet cycle
  assign crc5_error_o     = packet_end_i & is_token & ~crc5_ok_i;
  assign crc16_error_o    = packet_end_i & is_data & ~crc16_ok_i;
  assign pid_error_o      = packet_end_i & ~pid_ok;
  assign bitstuff_error_o = packet_end_i & bitstuff_err_i;

endmodule

//--- src/usb_rx_crc_check.sv
/*
 * USB serial CRC checker
 * shifts the received bits through an LFSR and flags the good residue
 */
`timescale 1ns/1ps

module usb_rx_crc_check #(
  parameter type  crc_t   = logic [4:0],
  parameter crc_t POLY    = '0,
  parameter crc_t RESIDUE = '0
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic clear_i,
  input  logic bit_i,
  input  logic bit_valid_i,
  output logic crc_ok_o
);

  localparam int unsigned Width = $bits(crc_t);

  crc_t crc_q;
  logic feedback;

  // bits arrive least significant first, the msb of the register closes the loop
  assign feedback = bit_i ^ crc_q[Width-1];

  // preset to all ones for each packet as the USB CRCs require
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      crc_q <= '1;
    end else if (clear_i) begin
      crc_q <= '1;
    end else if (bit_valid_i) begin
      crc_q <= {crc_q[Width-2:0], 1'b0} ^ (feedback ? POLY : crc_t'('0));
    end
  end

  // with the inverted CRC shifted in, a clean packet leaves the fixed residue
  assign crc_ok_o = (crc_q == RESIDUE);

endmodule

//--- src/usb_rx_bit_decoder.sv
/*
 * USB receive bit decoder
 * NRZI decode, stuffed zero removal and bit stuffing error detection
 */
`timescale 1ns/1ps

module usb_rx_bit_decoder
  import usb_rx_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [3:0] sym_history_i,
  input  logic       sample_valid_i,
  input  logic       packet_valid_i,
  input  logic       packet_start_i,
  input  logic       packet_end_i,
  output logic       din_o,
  output logic       dvalid_o,
  output logic       bitstuff_err_o
);

  logic       prev_is_kj, curr_is_kj;
  logic       din_raw, dvalid_raw, stuff_bit;
  logic [6:0] ones_q;

  // only K and J carry data, SE0 or DT in the pair is not a bit
  assign prev_is_kj = sym_history_i[3] ^ sym_history_i[2];
  assign curr_is_kj = sym_history_i[1] ^ sym_history_i[0];

  // NRZI: no change is a one, a change is a zero
  assign din_raw    = (sym_history_i[3:2] == sym_history_i[1:0]);
  assign dvalid_raw = packet_valid_i & sample_valid_i & ~packet_end_i &
                      prev_is_kj & curr_is_kj;

  // the bit after a full run of ones is the stuffed zero
  assign stuff_bit = &ones_q[STUFF_RUN-1:0];

  // the history also takes the stuffed bit, so a proper zero breaks the run
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ones_q <= '0;
    end else if (packet_end_i) begin
      ones_q <= '0;
    end else if (dvalid_raw) begin
      ones_q <= {ones_q[5:0], din_raw};
    end
  end

  // seven ones in a row are illegal, the flag holds until the next PID
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bitstuff_err_o <= 1'b0;
    end else if (packet_start_i) begin
      bitstuff_err_o <= 1'b0;
    end else if (&ones_q) begin
      bitstuff_err_o <= 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dvalid_o <= 1'b0;
    end else begin
      dvalid_o <= dvalid_raw & ~stuff_bit;
    end
  end

  always_ff @(posedge clk_i) begin
    din_o <= din_raw;
  end

endmodule

//--- src/usb_rx_framer.sv
/*
 * USB receive framer
 * keeps the sampled symbol history, finds sync and end of packet
 */
`timescale 1ns/1ps

module usb_rx_framer
  import usb_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  line_state_e line_state_i,
  input  logic        sample_valid_i,
  input  logic        bitstuff_err_i,
  output logic [3:0]  sym_history_o,
  output logic        packet_valid_o,
  output logic        packet_start_o,
  output logic        packet_end_o,
  output logic        sop_o
);

  logic [11:0] history_q;
  logic        packet_valid_q, packet_valid_d;
  logic        in_packet_q;
  logic        se0_eop, see_eop;

  // six sampled symbols, two bits each, newest in the low bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // the line is taken as idle J after reset
      history_q <= 12'hAAA;
    end else if (sample_valid_i) begin
      history_q <= {history_q[9:0], line_state_i[1:0]};
    end
  end

  // two SE0 samples in a row end the packet on the line
  assign se0_eop = (history_q[3:0] == 4'b0000);
  // a bit stuffing error cuts the packet short
  assign see_eop = se0_eop | bitstuff_err_i;

  // J followed by K outside a packet is the first edge of sync
  assign sop_o = (history_q[3:0] == 4'b1001) & ~in_packet_q;

  // in_packet only follows the line, so a bit stuffing error cannot restart sop
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_packet_q <= 1'b0;
    end else if (se0_eop) begin
      in_packet_q <= 1'b0;
    end else if (sop_o) begin
      in_packet_q <= 1'b1;
    end
  end

  // packet_valid only moves at the sample point and holds in between
  always_comb begin
    packet_valid_d = packet_valid_q;
    if (sample_valid_i) begin
      if (!packet_valid_q && (history_q == SYNC_HISTORY)) begin
        packet_valid_d = 1'b1;
      end else if (packet_valid_q && see_eop) begin
        packet_valid_d = 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      packet_valid_q <= 1'b0;
    end else begin
      packet_valid_q <= packet_valid_d;
    end
  end

  // start pulses as the PID begins, not at the start of sync
  assign packet_start_o = packet_valid_d & ~packet_valid_q;
  assign packet_end_o   = ~packet_valid_d & packet_valid_q;
  assign packet_valid_o = packet_valid_q;
  assign sym_history_o  = history_q[3:0];

endmodule

//--- src/usb_rx_line_recovery.sv
/*
 * USB receive line recovery
 * settles the D+/D- pair into line states and recovers the bit phase
 */
`timescale 1ns/1ps

module usb_rx_line_recovery
  import usb_rx_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        usb_dp_i,
  input  logic        usb_dn_i,
  output line_state_e line_state_o,
  output logic        sample_valid_o,
  output logic        bit_strobe_o
);

  logic [1:0]  dpair;
  line_state_e state_q, state_d;
  logic [1:0]  phase_q;

  assign dpair = {usb_dp_i, usb_dn_i};

  //////////////////////////////////////////////////
  // line state tracking
  //////////////////////////////////////////////////

  // any change on the pair parks the state in DT for one clock
  // the pair is only taken on the clock after, so D+/D- skew is absorbed
  always_comb begin
    state_d = state_q;
    if (state_q == DT) begin
      state_d = line_state_e'({1'b0, dpair});
    end else if (dpair != state_q[1:0]) begin
      state_d = DT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SE0;
    end else begin
      state_q <= state_d;
    end
  end

  assign line_state_o = state_q;

  //////////////////////////////////////////////////
  // bit clock recovery
  //////////////////////////////////////////////////

  // each transition realigns the phase, so the sample lands mid bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= 2'd0;
    end else if (state_q == DT) begin
      phase_q <= 2'd0;
    end else begin
      phase_q <= phase_q + 2'd1;
    end
  end

  // phase 1 is the middle of the bit, phase 2 marks the bit for the transmit side
  assign sample_valid_o = (phase_q == 2'd1);
  assign bit_strobe_o   = (phase_q == 2'd2);

endmodule

//--- src/usb_rx_pkg.sv
/*
 * USB full-speed receiver package
 * line states, PID codes, packet classes and CRC constants shared by the stages
 */
package usb_rx_pkg;

  // sampled line state, the low two bits are the D+/D- levels
  typedef enum logic [2:0] {
    SE0 = 3'b000,
    DK  = 3'b001,
    DJ  = 3'b010,
    DT  = 3'b100
  } line_state_e;

  // PID values as they appear in the low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_SETUP = 4'b1101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010,
    PID_STALL = 4'b1110
  } usb_pid_e;

  // packet class, taken from PID bits [1:0]
  typedef enum logic [1:0] {
    KIND_TOKEN     = 2'b01,
    KIND_HANDSHAKE = 2'b10,
    KIND_DATA      = 2'b11
  } pid_kind_e;

  typedef logic [4:0]  crc5_t;
  typedef logic [15:0] crc16_t;

  localparam crc5_t  CRC5_POLY      = 5'b00101;
  localparam crc5_t  CRC5_RESIDUE   = 5'b01100;
  localparam crc16_t CRC16_POLY     = 16'h8005;
  localparam crc16_t CRC16_RESIDUE  = 16'h800D;

  // two bits per symbol, the tail of sync is K J K J K K
  localparam logic [11:0] SYNC_HISTORY = 12'b01_10_01_10_01_01;

  // a zero is stuffed after this many ones
  localparam int unsigned STUFF_RUN = 6;

endpackage
